// File: logic/lift_pkg.sv
// floor constants, call mask and floor types, engine and door command codes
`default_nettype none

package lift_pkg;

	localparam int FLOORS = 8;
	localparam int DEFAULT_DWELL = 8;	// door dwell in clock cycles

	typedef logic [2:0] floor_t;	// floor number
	typedef logic [7:0] floor_mask_t;	// one bit per floor

	// engine command
	typedef logic [1:0] engine_t;
	localparam engine_t ENGINE_STOP = 2'd0;
	localparam engine_t ENGINE_DOWN = 2'd1;
	localparam engine_t ENGINE_UP = 2'd2;

	// door motor command
	typedef logic [1:0] door_cmd_t;
	localparam door_cmd_t DOOR_HOLD = 2'd0;
	localparam door_cmd_t DOOR_OPEN = 2'd1;
	localparam door_cmd_t DOOR_CLOSE = 2'd2;

endpackage

`default_nettype wire

// File: logic/call_if.sv
// call interface with pending call masks and serve clear strobes
`timescale 1ns/10ps
`default_nettype none

interface call_if;
	import lift_pkg::*;

	floor_mask_t cab;	// pending cab calls
	floor_mask_t hall_up;
	floor_mask_t hall_down;

	logic clear_cab;	// one cycle strobes
	logic clear_up;
	logic clear_down;
	floor_t clear_floor;	// floor being served

	modport registers (
		output cab, hall_up, hall_down,
		input clear_cab, clear_up, clear_down, clear_floor
	);

	modport travel (
		input cab, hall_up, hall_down,
		output clear_cab, clear_up, clear_down, clear_floor
	);

endinterface

`default_nettype wire

// File: logic/call_register.sv
// call_register: cab and hall button latches with lamp clearing on service
`timescale 1ns/10ps
`default_nettype none

module call_register (
	input wire logic clk,
	input wire logic reset,
	input wire lift_pkg::floor_mask_t btn_in,
	input wire lift_pkg::floor_mask_t btn_up_out,
	input wire lift_pkg::floor_mask_t btn_down_out,
	call_if.registers calls
);
	import lift_pkg::*;

	// no up button on the top floor, no down button on floor 0
	localparam floor_mask_t UP_VALID = ~(floor_mask_t'(1) << (FLOORS - 1));
	localparam floor_mask_t DOWN_VALID = ~floor_mask_t'(1);

	floor_mask_t serve_bit;
	floor_mask_t clr_cab;
	floor_mask_t clr_up;
	floor_mask_t clr_down;

	assign serve_bit = floor_mask_t'(1) << calls.clear_floor;
	assign clr_cab = calls.clear_cab ? serve_bit : '0;
	assign clr_up = calls.clear_up ? serve_bit : '0;
	assign clr_down = calls.clear_down ? serve_bit : '0;

	// clear beats a press on the same bit
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			calls.cab <= '0;
			calls.hall_up <= '0;
			calls.hall_down <= '0;
		end else begin
			calls.cab <= (calls.cab | btn_in) & ~clr_cab;
			calls.hall_up <= (calls.hall_up | (btn_up_out & UP_VALID)) & ~clr_up;
			calls.hall_down <= (calls.hall_down | (btn_down_out & DOWN_VALID)) & ~clr_down;
		end
	end

endmodule

`default_nettype wire

// File: logic/door_control.sv
// door_control: door FSM with dwell timer and reopen on obstruction, overload or open button
`timescale 1ns/10ps
`default_nettype none

module door_control #(
	parameter int DWELL_CYCLES = lift_pkg::DEFAULT_DWELL
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic open_req,
	input wire logic sensor_door,	// 0 open, 1 closed
	input wire logic sensor_inside,
	input wire logic overload,
	input wire logic open_btn,
	output lift_pkg::door_cmd_t door,
	output logic door_busy,
	output logic door_done
);
	import lift_pkg::*;

	localparam int CNT_W = $clog2(DWELL_CYCLES + 1);

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_OPENING,
		DS_DWELL,
		DS_CLOSING
	} door_state_t;

	door_state_t state;
	logic [CNT_W-1:0] dwell_cnt;
	logic reopen;

	assign reopen = sensor_inside | overload | open_btn;
	assign door_busy = (state != DS_IDLE);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= DS_IDLE;
			dwell_cnt <= '0;
			door_done <= 1'b0;
		end else begin
			door_done <= 1'b0;
			case (state)
				DS_IDLE: begin
					if (open_req)
						state <= DS_OPENING;
				end
				DS_OPENING: begin
					if (!sensor_door) begin	// fully open
						state <= DS_DWELL;
						dwell_cnt <= CNT_W'(DWELL_CYCLES - 1);
					end
				end
				DS_DWELL: begin
					if (dwell_cnt == '0)
						state <= DS_CLOSING;
					else
						dwell_cnt <= dwell_cnt - 1'b1;
				end
				DS_CLOSING: begin
					if (reopen) begin
						state <= DS_OPENING;	// back out, doorway not clear
					end else if (sensor_door) begin
						state <= DS_IDLE;
						door_done <= 1'b1;
					end
				end
				default: state <= DS_IDLE;
			endcase
		end
	end

	always_comb begin
		case (state)
			DS_OPENING: door = DOOR_OPEN;
			DS_CLOSING: door = DOOR_CLOSE;
			default: door = DOOR_HOLD;	// idle and dwell
		endcase
	end

endmodule

`default_nettype wire

// File: logic/travel_control.sv
// travel_control: car FSM with floor tracking, direction policy, stop decision and call clearing
`timescale 1ns/10ps
`default_nettype none

module travel_control (
	input wire logic clk,
	input wire logic reset,
	input wire logic sensor_up,
	input wire logic sensor_down,
	input wire logic door_busy,
	input wire logic door_done,
	call_if.travel calls,
	output logic open_req,
	output lift_pkg::engine_t engine,
	output lift_pkg::floor_t level_display
);
	import lift_pkg::*;

	typedef enum logic [1:0] {
		ST_PARKED,
		ST_RUNNING,
		ST_STOPPING,
		ST_DOOR_WAIT
	} travel_state_t;

	travel_state_t state;
	floor_t cur_floor;
	logic dir;	// 1 up, 0 down
	logic aligned_q;

	logic aligned;
	logic align_rise;
	floor_mask_t all_calls;

	// bits strictly above floor f
	function automatic floor_mask_t above_mask(floor_t f);
		return ~((floor_mask_t'(2) << f) - floor_mask_t'(1));
	endfunction

	// bits strictly below floor f
	function automatic floor_mask_t below_mask(floor_t f);
		return (floor_mask_t'(1) << f) - floor_mask_t'(1);
	endfunction

	// arrival at the next floor
	floor_t next_floor;
	floor_mask_t next_bit;
	logic cab_next, up_next, dn_next;
	logic ahead_next, dir_hall_next, opp_next;
	logic stop_next, reverse_next;

	// decision at the current floor
	floor_mask_t cur_bit;
	logic up_cur, dn_cur;
	logic ahead_cur, behind_cur, here_cur, here_dir;
	logic decide;

	assign aligned = sensor_up & sensor_down;
	assign align_rise = aligned & ~aligned_q & (state == ST_RUNNING);
	assign all_calls = calls.cab | calls.hall_up | calls.hall_down;

	assign next_floor = dir ? cur_floor + 1'b1 : cur_floor - 1'b1;
	assign next_bit = floor_mask_t'(1) << next_floor;
	assign cab_next = |(calls.cab & next_bit);
	assign up_next = |(calls.hall_up & next_bit);
	assign dn_next = |(calls.hall_down & next_bit);
	assign ahead_next = dir ? |(all_calls & above_mask(next_floor))
		: |(all_calls & below_mask(next_floor));
	assign dir_hall_next = dir ? up_next : dn_next;
	assign opp_next = dir ? dn_next : up_next;
	assign stop_next = cab_next | dir_hall_next | ~ahead_next;	// end of run always stops
	assign reverse_next = ~ahead_next & ~dir_hall_next & opp_next;

	assign cur_bit = floor_mask_t'(1) << cur_floor;
	assign up_cur = |(calls.hall_up & cur_bit);
	assign dn_cur = |(calls.hall_down & cur_bit);
	assign here_cur = |(all_calls & cur_bit);
	assign ahead_cur = dir ? |(all_calls & above_mask(cur_floor))
		: |(all_calls & below_mask(cur_floor));
	assign behind_cur = dir ? |(all_calls & below_mask(cur_floor))
		: |(all_calls & above_mask(cur_floor));
	assign here_dir = (up_cur & dn_cur) ? dir : (up_cur | (~dn_cur & dir));	// both lit keeps dir
	assign decide = ((state == ST_PARKED) & ~door_busy) | ((state == ST_DOOR_WAIT) & door_done);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= ST_PARKED;
			cur_floor <= '0;
			dir <= 1'b1;
			aligned_q <= 1'b0;
			engine <= ENGINE_STOP;
		end else begin
			aligned_q <= aligned;
			if (decide) begin
				if (ahead_cur) begin
					engine <= dir ? ENGINE_UP : ENGINE_DOWN;
					state <= ST_RUNNING;
				end else if (behind_cur) begin
					dir <= ~dir;
					engine <= dir ? ENGINE_DOWN : ENGINE_UP;
					state <= ST_RUNNING;
				end else if (here_cur) begin
					dir <= here_dir;	// reopen for a call at this floor
					state <= ST_STOPPING;
				end else begin
					state <= ST_PARKED;
				end
			end else begin
				case (state)
					ST_RUNNING: begin
						if (align_rise) begin
							cur_floor <= next_floor;
							if (stop_next) begin
								engine <= ENGINE_STOP;
								state <= ST_STOPPING;
								if (reverse_next)
									dir <= ~dir;
							end
						end
					end
					ST_STOPPING: state <= ST_DOOR_WAIT;	// open_req and clears this cycle
					default: ;
				endcase
			end
		end
	end

	assign open_req = (state == ST_STOPPING);
	assign calls.clear_cab = (state == ST_STOPPING);
	assign calls.clear_up = (state == ST_STOPPING) & dir;	// leaving direction only
	assign calls.clear_down = (state == ST_STOPPING) & ~dir;
	assign calls.clear_floor = cur_floor;
	assign level_display = cur_floor;

endmodule

`default_nettype wire

// File: logic/lift_top.sv
// lift_top: elevator controller top level joining call register, travel control and door control
`timescale 1ns/10ps
`default_nettype none

module lift_top #(
	parameter int DWELL_CYCLES = lift_pkg::DEFAULT_DWELL
) (
	input wire logic clk,
	input wire logic reset,
	input wire lift_pkg::floor_mask_t btn_in,
	input wire lift_pkg::floor_mask_t btn_up_out,
	input wire lift_pkg::floor_mask_t btn_down_out,
	input wire logic open_btn,
	input wire logic overload,
	input wire logic sensor_inside,
	input wire logic sensor_up,
	input wire logic sensor_down,
	input wire logic sensor_door,
	output lift_pkg::engine_t engine,
	output lift_pkg::door_cmd_t door,
	output lift_pkg::floor_t level_display,
	output lift_pkg::floor_mask_t lamp_in,
	output lift_pkg::floor_mask_t lamp_up,
	output lift_pkg::floor_mask_t lamp_down
);

	logic open_req;
	logic door_busy;
	logic door_done;

	call_if calls ();

	call_register u_call_register (
		.clk (clk),
		.reset (reset),
		.btn_in (btn_in),
		.btn_up_out (btn_up_out),
		.btn_down_out (btn_down_out),
		.calls (calls.registers)
	);

	travel_control u_travel_control (
		.clk (clk),
		.reset (reset),
		.sensor_up (sensor_up),
		.sensor_down (sensor_down),
		.door_busy (door_busy),
		.door_done (door_done),
		.calls (calls.travel),
		.open_req (open_req),
		.engine (engine),
		.level_display (level_display)
	);

	door_control #(
		.DWELL_CYCLES (DWELL_CYCLES)
	) u_door_control (
		.clk (clk),
		.reset (reset),
		.open_req (open_req),
		.sensor_door (sensor_door),
		.sensor_inside (sensor_inside),
		.overload (overload),
		.open_btn (open_btn),
		.door (door),
		.door_busy (door_busy),
		.door_done (door_done)
	);

	// lamps show the pending calls
	assign lamp_in = calls.cab;
	assign lamp_up = calls.hall_up;
	assign lamp_down = calls.hall_down;

endmodule

`default_nettype wire

// File: verif/lift_asserts.sv
// bound safety assertions on the elevator top-level ports
`timescale 1ns/10ps
`default_nettype none

module lift_asserts (
	input wire logic clk,
	input wire logic reset,
	input wire lift_pkg::engine_t engine,
	input wire lift_pkg::door_cmd_t door,
	input wire lift_pkg::floor_t level_display,
	input wire lift_pkg::floor_mask_t lamp_up,
	input wire lift_pkg::floor_mask_t lamp_down
);
	import lift_pkg::*;

	logic failed = 1'b0;	// set once any assertion fails

	door_stops_car: assert property (@(posedge clk) disable iff (!reset)
		door != DOOR_HOLD |-> engine == ENGINE_STOP)
	else begin
		$error("engine running while the door motor moves");
		failed = 1'b1;
	end

	// display steps one floor per alignment while the engine runs
	display_one_step: assert property (@(posedge clk) disable iff (!reset)
		level_display != $past(level_display) |->
		$past(engine) != ENGINE_STOP
		&& (level_display == $past(level_display) + 1
		|| level_display + 1 == $past(level_display)))
	else begin
		$error("level display jumped or moved with the engine stopped");
		failed = 1'b1;
	end

	no_missing_hall_lamps: assert property (@(posedge clk) disable iff (!reset)
		!lamp_up[FLOORS-1] && !lamp_down[0])
	else begin
		$error("lamp lit for a hall button that does not exist");
		failed = 1'b1;
	end

	// never drive past the shaft ends
	travel_limits: assert property (@(posedge clk) disable iff (!reset)
		!(level_display == FLOORS - 1 && engine == ENGINE_UP)
		&& !(level_display == 0 && engine == ENGINE_DOWN))
	else begin
		$error("engine driving past the end of the shaft");
		failed = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/lift_tb.sv
// elevator testbench with building model, directed tests, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module lift_tb;
	import lift_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int DWELL = DEFAULT_DWELL;
	localparam int MAX_TEST_CYCLES = 300;	// longest directed test
	localparam int WATCHDOG_NS = (6 * MAX_TEST_CYCLES + 200) * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	floor_mask_t btn_in, btn_up_out, btn_down_out;
	logic open_btn, overload, sensor_inside;
	logic sensor_up, sensor_down, sensor_door;
	engine_t engine;
	door_cmd_t door;
	floor_t level_display;
	floor_mask_t lamp_in, lamp_up, lamp_down;
	int run_cnt = 0;	// cycles since the car left a floor
	int open_cnt = 0;
	int close_cnt = 0;

	lift_top #(.DWELL_CYCLES(DWELL)) UUT (.*);

	bind lift_top lift_asserts u_lift_asserts (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// building model for the shaft sensors and the door
	always @(posedge clk) begin
		#1;
		run_cnt = (engine == ENGINE_STOP) ? 0 : (run_cnt + 1) % 8;
		sensor_up = (run_cnt >= 6);	// level with a floor for 2 cycles
		sensor_down = (run_cnt >= 6);
		open_cnt = (door == DOOR_OPEN) ? open_cnt + 1 : 0;
		close_cnt = (door == DOOR_CLOSE) ? close_cnt + 1 : 0;
		if (open_cnt == 3)
			sensor_door = 1'b0;	// fully open
		if (close_cnt == 3)
			sensor_door = 1'b1;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input logic ok, input string msg);
		assert (ok)
		else report_error($sformatf("mismatch at %0t ns: %s", $time, msg));
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic press(input floor_mask_t cab, input floor_mask_t up, input floor_mask_t down);
		step();
		btn_in = cab;
		btn_up_out = up;
		btn_down_out = down;
		step();
		btn_in = '0;
		btn_up_out = '0;
		btn_down_out = '0;
	endtask

	task automatic wait_door(input door_cmd_t want, input int limit, input string what);
		int n = 0;
		@(negedge clk);
		while (door != want) begin
			n++;
			if (n > limit)
				report_error($sformatf("timed out at %0t ns waiting for %s", $time, what));
			@(negedge clk);
		end
	endtask

	task automatic wait_level(input floor_t want, input int limit, input string what);
		int n = 0;
		@(negedge clk);
		while (level_display != want) begin
			n++;
			if (n > limit)
				report_error($sformatf("timed out at %0t ns waiting for %s", $time, what));
			@(negedge clk);
		end
	endtask

	// dwell, close, then the door sensed shut
	task automatic finish_door();
		wait_door(DOOR_HOLD, 8, "door dwell");
		wait_door(DOOR_CLOSE, DWELL + 6, "door closing");
		wait_door(DOOR_HOLD, 8, "door closed");
		check_value(engine == ENGINE_STOP, "engine moved before the door closed");
	endtask

	task automatic pulse_reopen(input int src);
		step();
		case (src)
			0: sensor_inside = 1'b1;
			1: overload = 1'b1;
			default: open_btn = 1'b1;
		endcase
		step();
		sensor_inside = 1'b0;
		overload = 1'b0;
		open_btn = 1'b0;
	endtask

	task automatic check_reset_state();
		check_value(engine == ENGINE_STOP, "engine not stopped after reset");
		check_value(door == DOOR_HOLD, "door not held after reset");
		check_value(level_display == 0, "display not at floor 0 after reset");
		check_value((lamp_in | lamp_up | lamp_down) == '0, "lamps lit after reset");
	endtask

	task automatic lamp_latching();
		press('0, 8'h80, 8'h01);	// top up and bottom down do not exist
		check_value(lamp_up == '0 && lamp_down == '0, "lamp lit for a missing hall button");
		press(8'h08, '0, '0);
		check_value(lamp_in == 8'h08, "cab lamp 3 not lit one cycle after the press");
	endtask

	task automatic travel_to_cab_call();
		step();	// departure decided one cycle after the lamp
		check_value(engine == ENGINE_UP, "engine not up toward floor 3");
		wait_level(1, 20, "floor 1");
		check_value(engine == ENGINE_UP, "car stopped at floor 1");
		wait_level(2, 20, "floor 2");
		check_value(engine == ENGINE_UP, "car stopped at floor 2");
		wait_level(3, 20, "floor 3");
		check_value(engine == ENGINE_STOP, "car did not stop at floor 3");
		wait_door(DOOR_OPEN, 10, "door opening at floor 3");
		check_value(lamp_in == '0, "cab lamp 3 still lit with the door open");
		finish_door();
	endtask

	task automatic door_reopening();
		int src;
		press(8'h08, '0, '0);	// call at the floor the car waits on
		wait_door(DOOR_OPEN, 10, "door opening at floor 3");
		for (src = 0; src < 3; src++) begin
			wait_door(DOOR_CLOSE, DWELL + 10, "door closing");
			pulse_reopen(src);	// inside, overload, open button
			wait_door(DOOR_OPEN, 3, "door reopening");
			check_value(engine == ENGINE_STOP, "engine moved during a reopen");
		end
		finish_door();
		repeat (3) step();
		check_value(engine == ENGINE_STOP && level_display == 3, "car left floor 3 with no calls");
	endtask

	task automatic direction_policy();
		press(8'h22, '0, '0);	// cab 5 and 1 in one cycle
		wait_level(5, 40, "floor 5");
		check_value(engine == ENGINE_STOP, "car passed floor 5");
		wait_door(DOOR_OPEN, 10, "door opening at floor 5");
		check_value(lamp_in == 8'h02, "cab lamps wrong once the door opened at floor 5");
		finish_door();
		step();
		check_value(engine == ENGINE_DOWN, "car did not reverse toward floor 1");
		wait_level(1, 50, "floor 1");
		check_value(engine == ENGINE_STOP, "car passed floor 1");
		wait_door(DOOR_OPEN, 10, "door opening at floor 1");
		finish_door();
		press(8'h10, '0, '0);
		step();
		check_value(engine == ENGINE_UP, "car did not head up toward floor 4");
		press('0, '0, 8'h40);	// hall down at 6 while moving up
		wait_level(4, 40, "floor 4");
		check_value(engine == ENGINE_STOP && lamp_down == 8'h40, "wrong state at floor 4");
		wait_door(DOOR_OPEN, 10, "door opening at floor 4");
		finish_door();
		wait_level(6, 40, "floor 6");
		check_value(engine == ENGINE_STOP, "hall down call at 6 not served");
		wait_door(DOOR_OPEN, 10, "door opening at floor 6");
		check_value(lamp_down == '0, "hall down lamp 6 still lit");
		finish_door();
	endtask

	task automatic hall_direction_clearing();
		int n = 0;
		press(8'h08, '0, '0);
		wait_level(3, 40, "floor 3");
		wait_door(DOOR_OPEN, 10, "door opening at floor 3");
		finish_door();
		press(8'h80, 8'h10, 8'h10);	// both hall lamps at 4, cab call above
		wait_level(4, 20, "floor 4");
		check_value(engine == ENGINE_STOP, "car passed floor 4");
		wait_door(DOOR_OPEN, 10, "door opening at floor 4");
		check_value(lamp_up == '0, "hall up lamp 4 not cleared");
		check_value(lamp_down == 8'h10, "hall down lamp 4 cleared while going up");
		finish_door();
		while (lamp_down != '0) begin	// up to 7, then back down to 4
			n++;
			if (n > 150)
				report_error("hall down call at floor 4 was never served");
			@(negedge clk);
		end
		finish_door();
		check_value(level_display == 4 && (lamp_in | lamp_up) == '0, "calls left after return");
	endtask

	initial begin
		reset = 1'b0;
		btn_in = '0;
		btn_up_out = '0;
		btn_down_out = '0;
		open_btn = 1'b0;
		overload = 1'b0;
		sensor_inside = 1'b0;
		sensor_up = 1'b0;
		sensor_down = 1'b0;
		sensor_door = 1'b1;	// door closed
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b1;
		check_reset_state();
		lamp_latching();
		travel_to_cab_call();
		door_reopening();
		direction_policy();
		hall_direction_clearing();
		if (UUT.u_lift_asserts.failed) begin
			report_error("a safety assertion on the lift ports failed");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

	always @(negedge clk)
		if (UUT.u_lift_asserts.failed)
			report_error("a safety assertion on the lift ports failed");

	initial begin
		#(WATCHDOG_NS);
		report_error($sformatf("watchdog expired at %0t ns before the tests finished", $time));
	end

endmodule

`default_nettype wire

// File: lift.f
logic/lift_pkg.sv
logic/call_if.sv
logic/call_register.sv
logic/door_control.sv
logic/travel_control.sv
logic/lift_top.sv
verif/lift_asserts.sv
verif/lift_tb.sv
